// ==== sources.f ====
histPkg.sv
ctrlPkg.sv
countRam.sv
histAccumulator.sv
peakScanner.sv
histPeakTop.sv
histPeakChecker.sv
histPeakTb.sv

// ==== Bender.yml ====
package:
  name: histPeak

sources:
  - histPkg.sv
  - ctrlPkg.sv
  - countRam.sv
  - histAccumulator.sv
  - peakScanner.sv
  - histPeakTop.sv
  - target: test
    files:
      - histPeakChecker.sv
      - histPeakTb.sv

// ==== histPeakTb.sv ====
`default_nettype none

module histPeakTb
    import histPkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int NUM_ROWS = 6;
    localparam int REPORT_TIMEOUT = 100;
    localparam int READY_TIMEOUT = 50;
    localparam int RANDOM_SAMPLES = 240;

    // one run of identical samples
    typedef struct packed {
        logic [PIX_W-1:0] pix;
        logic [BIN_W-1:0] bin;
        logic [15:0] reps;
    } sampleEntry_t;

    // one frame of stimulus and its expected peaks
    typedef struct packed {
        sampleEntry_t [0:3] ent;
        logic backToBack;
        logic invalidCycles;
        logic [0:3][BIN_W-1:0] expBin;
        logic [0:3][COUNT_W-1:0] expCount;
    } frameRow_t;

    localparam sampleEntry_t NO_ENTRY = '0;

    logic clk;
    logic rst;
    logic sampleValid;
    logic [PIX_W-1:0] samplePixel;
    logic [BIN_W-1:0] sampleBin;
    logic frameDone;
    logic acqReady;
    logic peakValid;
    logic [PIX_W-1:0] peakPixel;
    logic [BIN_W-1:0] peakBin;
    logic [COUNT_W-1:0] peakCount;

    frameRow_t frameTable [NUM_ROWS];
    string rowName [NUM_ROWS];
    // reference histogram for the random frame
    logic [COUNT_W-1:0] modelCount [RAM_DEPTH];
    logic [BIN_W-1:0] expBin [PIXEL_NUM];
    logic [COUNT_W-1:0] expCount [PIXEL_NUM];
    logic [31:0] lcgState;
    int junkCnt;

    histPeakTop dut0 (
        .clk        (clk),
        .rst        (rst),
        .sampleValid(sampleValid),
        .samplePixel(samplePixel),
        .sampleBin  (sampleBin),
        .frameDone  (frameDone),
        .acqReady   (acqReady),
        .peakValid  (peakValid),
        .peakPixel  (peakPixel),
        .peakBin    (peakBin),
        .peakCount  (peakCount)
    );

    bind histPeakTop histPeakChecker chk0 (
        .clk      (clk),
        .rst      (rst),
        .acqReady (acqReady),
        .peakValid(peakValid)
    );

    always #10 clk = ~clk;

    // protocol assertions in the bound checker
    always @(posedge clk) begin
        if (dut0.chk0.errCount != 0) begin
            failNow("protocol assertion failed in histPeakChecker");
        end
    end

    function automatic logic [31:0] lcgNext(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic checkEq(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
        if (expected !== actual) begin
            $display("Mismatch in %s: expected %0d, actual %0d", name, expected, actual);
            $display("STATUS: FAIL");
            $fatal(1, "value check failed");
        end
    endtask

    task automatic failNow(input string what);
        $display("%s", what);
        $display("STATUS: FAIL");
        $fatal(1, "run aborted");
    endtask

    // outputs are settled and inputs change 2 ns after the edge
    task automatic nextCycle();
        @(posedge clk);
        #2;
    endtask

    task automatic driveIdle();
        sampleValid = 1'b0;
        frameDone = 1'b0;
    endtask

    // traffic that must be dropped while acqReady is low
    task automatic driveJunk();
        sampleValid = 1'b1;
        frameDone = 1'b1;
        samplePixel = junkCnt[PIX_W-1:0];
        sampleBin = junkCnt[PIX_W +: BIN_W];
        junkCnt = junkCnt + 7;
    endtask

    task automatic waitReady(input string name);
        int cycles;
        cycles = 0;
        while (!acqReady) begin
            if (cycles == READY_TIMEOUT) begin
                failNow({"timed out waiting for acqReady in ", name});
            end else begin
                driveJunk();
                nextCycle();
                cycles++;
            end
        end
        driveIdle();
    endtask

    // last sample of a frame rides with frameDone
    task automatic sendSample(input logic [PIX_W-1:0] pix, input logic [BIN_W-1:0] bin,
                              input logic last, input logic backToBack,
                              input logic invalidCycles);
        sampleValid = 1'b1;
        samplePixel = pix;
        sampleBin = bin;
        frameDone = last;
        nextCycle();
        driveIdle();
        if (!last) begin
            if (!backToBack) begin
                nextCycle();
            end
            // invalid cycle with a different address on the bus
            if (invalidCycles) begin
                samplePixel = ~pix;
                sampleBin = ~bin;
                nextCycle();
            end
        end
    endtask

    task automatic collectReports(input string name);
        int cycles;
        string tag;
        for (int k = 0; k < PIXEL_NUM; k++) begin
            cycles = 0;
            tag = $sformatf("%s pixel %0d", name, k);
            while (!peakValid) begin
                if (cycles == REPORT_TIMEOUT) begin
                    failNow({"timed out waiting for peakValid in ", tag});
                end else begin
                    if (acqReady) driveIdle();
                    else driveJunk();
                    nextCycle();
                    cycles++;
                end
            end
            checkEq({tag, " index"}, k, peakPixel);
            checkEq({tag, " bin"}, expBin[k], peakBin);
            checkEq({tag, " count"}, expCount[k], peakCount);
            driveJunk();
            nextCycle();
        end
    endtask

    task automatic runRow(input int r);
        frameRow_t row;
        int total;
        int sent;
        row = frameTable[r];
        total = 0;
        sent = 0;
        for (int e = 0; e < 4; e++) total += row.ent[e].reps;
        waitReady(rowName[r]);
        if (total == 0) begin
            // empty frame, bare frameDone
            frameDone = 1'b1;
            nextCycle();
            driveIdle();
        end
        for (int e = 0; e < 4; e++) begin
            for (int i = 0; i < row.ent[e].reps; i++) begin
                sent++;
                sendSample(row.ent[e].pix, row.ent[e].bin, sent == total,
                           row.backToBack, row.invalidCycles);
            end
        end
        for (int p = 0; p < PIXEL_NUM; p++) begin
            expBin[p] = row.expBin[p];
            expCount[p] = row.expCount[p];
        end
        collectReports(rowName[r]);
        waitReady(rowName[r]);
    endtask

    task automatic runRandom();
        logic [ADDR_W-1:0] addr;
        for (int a = 0; a < RAM_DEPTH; a++) modelCount[a] = '0;
        waitReady("randomFrame");
        for (int i = 0; i < RANDOM_SAMPLES; i++) begin
            lcgState = lcgNext(lcgState);
            addr = lcgState[31 -: ADDR_W];
            // saturating increment
            if (modelCount[addr] != {COUNT_W{1'b1}}) modelCount[addr] = modelCount[addr] + 1'b1;
            sendSample(addr[ADDR_W-1 -: PIX_W], addr[BIN_W-1:0], i == RANDOM_SAMPLES - 1,
                       lcgState[20], lcgState[21] & lcgState[22]);
        end
        for (int p = 0; p < PIXEL_NUM; p++) begin
            expBin[p] = '0;
            expCount[p] = '0;
            // strictly greater, ties stay on the lower bin
            for (int b = 0; b < BIN_NUM; b++) begin
                if (modelCount[p * BIN_NUM + b] > expCount[p]) begin
                    expCount[p] = modelCount[p * BIN_NUM + b];
                    expBin[p] = BIN_W'(b);
                end
            end
        end
        collectReports("randomFrame");
        waitReady("randomFrame");
    endtask

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        sampleValid = 1'b0;
        samplePixel = '0;
        sampleBin = '0;
        frameDone = 1'b0;
        junkCnt = 0;
        lcgState = 32'hc5195f26;

        // repeated address in consecutive cycles, forwarding path
        rowName[0] = "fwdCount";
        frameTable[0] = '{'{'{2'd1, 4'd5, 16'd7}, '{2'd1, 4'd6, 16'd3},
            '{2'd3, 4'd15, 16'd2}, NO_ENTRY}, 1'b1, 1'b0,
            '{4'd0, 4'd5, 4'd0, 4'd15}, '{8'd0, 8'd7, 8'd0, 8'd2}};
        rowName[1] = "gapCount";
        frameTable[1] = '{'{'{2'd0, 4'd2, 16'd4}, '{2'd2, 4'd7, 16'd5},
            '{2'd2, 4'd7, 16'd1}, NO_ENTRY}, 1'b0, 1'b1,
            '{4'd2, 4'd0, 4'd7, 4'd0}, '{8'd4, 8'd0, 8'd6, 8'd0}};
        // equal counts, lower bin wins
        rowName[2] = "tieLow";
        frameTable[2] = '{'{'{2'd0, 4'd9, 16'd3}, '{2'd0, 4'd4, 16'd3},
            '{2'd3, 4'd1, 16'd2}, '{2'd3, 4'd0, 16'd2}}, 1'b1, 1'b1,
            '{4'd4, 4'd0, 4'd0, 4'd0}, '{8'd3, 8'd0, 8'd0, 8'd2}};
        rowName[3] = "saturate";
        frameTable[3] = '{'{'{2'd2, 4'd11, 16'd300}, '{2'd2, 4'd12, 16'd254},
            '{2'd1, 4'd3, 16'd255}, NO_ENTRY}, 1'b1, 1'b0,
            '{4'd0, 4'd3, 4'd11, 4'd0}, '{8'd0, 8'd255, 8'd255, 8'd0}};
        // previous scan must have cleared everything
        rowName[4] = "emptyAfter";
        frameTable[4] = '{'{NO_ENTRY, NO_ENTRY, NO_ENTRY, NO_ENTRY}, 1'b1, 1'b0,
            '{4'd0, 4'd0, 4'd0, 4'd0}, '{8'd0, 8'd0, 8'd0, 8'd0}};
        // only sample comes with frameDone, junk before it was dropped
        rowName[5] = "dropInput";
        frameTable[5] = '{'{'{2'd2, 4'd9, 16'd1}, NO_ENTRY, NO_ENTRY, NO_ENTRY}, 1'b1, 1'b0,
            '{4'd0, 4'd0, 4'd9, 4'd0}, '{8'd0, 8'd0, 8'd1, 8'd0}};

        repeat (16) @(posedge clk);
        #2;
        rst = 1'b0;

        for (int r = 0; r < NUM_ROWS; r++) begin
            runRow(r);
        end
        runRandom();

        if (dut0.chk0.errCount == 0) begin
            $display("STATUS: PASS");
            $finish;
        end else begin
            failNow("protocol assertion failed in histPeakChecker");
        end
    end

endmodule

`default_nettype wire

// ==== histPeakChecker.sv ====
`default_nettype none

module histPeakChecker (
    input wire logic clk,
    input wire logic rst,
    input wire logic acqReady,
    input wire logic peakValid
);

    timeunit 1ns;
    timeprecision 100ps;

    // failed assertions so far
    int errCount = 0;

    // reports only come out while acquisition is closed
    noPeakWhileReady: assert property (
        @(posedge clk) disable iff (rst) !(peakValid && acqReady)
    ) else begin
        errCount++;
        $error("peakValid high while acqReady is high");
    end

    // accumulator leaves reset in the run phase
    readyAfterReset: assert property (
        @(posedge clk) $fell(rst) |-> acqReady
    ) else begin
        errCount++;
        $error("acqReady low in the first cycle after reset");
    end

    // one pulse per pixel, never two in a row
    singlePeakPulse: assert property (
        @(posedge clk) disable iff (rst) peakValid |=> !peakValid
    ) else begin
        errCount++;
        $error("peakValid high on two consecutive cycles");
    end

endmodule

`default_nettype wire

// ==== histPeakTop.sv ====
`default_nettype none

module histPeakTop
    import histPkg::*;
(
    input  wire logic               clk,
    input  wire logic               rst,
    input  wire logic               sampleValid,
    input  wire logic [PIX_W-1:0]   samplePixel,
    input  wire logic [BIN_W-1:0]   sampleBin,
    input  wire logic               frameDone,
    output logic                    acqReady,
    output logic                    peakValid,
    output logic      [PIX_W-1:0]   peakPixel,
    output logic      [BIN_W-1:0]   peakBin,
    output logic      [COUNT_W-1:0] peakCount
);

    // accumulator to scanner handover
    logic scanStart;
    logic scanDone;

    // scanner requests, routed through the accumulator
    logic [ADDR_W-1:0] scanRaddr;
    logic [ADDR_W-1:0] scanWaddr;
    logic scanWe;

    // muxed ram ports
    logic [ADDR_W-1:0] ramRaddr;
    logic [ADDR_W-1:0] ramWaddr;
    logic ramWe;
    logic [COUNT_W-1:0] ramWdata;
    logic [COUNT_W-1:0] ramRdata;

    histAccumulator acc0 (
        .clk        (clk),
        .rst        (rst),
        .sampleValid(sampleValid),
        .samplePixel(samplePixel),
        .sampleBin  (sampleBin),
        .frameDone  (frameDone),
        .acqReady   (acqReady),
        .scanStart  (scanStart),
        .scanDone   (scanDone),
        .scanRaddr  (scanRaddr),
        .scanWaddr  (scanWaddr),
        .scanWe     (scanWe),
        .ramRaddr   (ramRaddr),
        .ramWaddr   (ramWaddr),
        .ramWe      (ramWe),
        .ramWdata   (ramWdata),
        .ramRdata   (ramRdata)
    );

    countRam ram0 (
        .clk  (clk),
        .we   (ramWe),
        .waddr(ramWaddr),
        .wdata(ramWdata),
        .raddr(ramRaddr),
        .rdata(ramRdata)
    );

    peakScanner scanner0 (
        .clk      (clk),
        .rst      (rst),
        .scanStart(scanStart),
        .scanDone (scanDone),
        .scanRaddr(scanRaddr),
        .scanWaddr(scanWaddr),
        .scanWe   (scanWe),
        .ramRdata (ramRdata),
        .peakValid(peakValid),
        .peakPixel(peakPixel),
        .peakBin  (peakBin),
        .peakCount(peakCount)
    );

endmodule

`default_nettype wire

// ==== peakScanner.sv ====
`default_nettype none

module peakScanner
    import histPkg::*;
    import ctrlPkg::*;
(
    input  wire logic               clk,
    input  wire logic               rst,
    input  wire logic               scanStart,
    output logic                    scanDone,
    output logic      [ADDR_W-1:0]  scanRaddr,
    output logic      [ADDR_W-1:0]  scanWaddr,
    output logic                    scanWe,
    input  wire logic [COUNT_W-1:0] ramRdata,
    output logic                    peakValid,
    output logic      [PIX_W-1:0]   peakPixel,
    output logic      [BIN_W-1:0]   peakBin,
    output logic      [COUNT_W-1:0] peakCount
);

    scanState_t state;

    // read position
    logic [PIX_W-1:0] pixCnt;
    logic [BIN_W-1:0] binCnt;
    logic lastBin;
    logic lastPixel;

    // address read last cycle, its data is on ramRdata now
    logic rdValid;
    logic [ADDR_W-1:0] rdAddr;

    // running maximum of the current pixel
    logic [COUNT_W-1:0] maxCount;
    logic [BIN_W-1:0] maxBin;
    logic newMax;

    assign lastBin = (binCnt == BIN_W'(BIN_NUM - 1));
    assign lastPixel = (pixCnt == PIX_W'(PIXEL_NUM - 1));
    assign scanRaddr = {pixCnt, binCnt};

    // zero goes to the word whose data is returning
    assign scanWe = rdValid;
    assign scanWaddr = rdAddr;

    // strict compare, a tie keeps the lower bin
    assign newMax = rdValid && (ramRdata > maxCount);

    always_ff @(posedge clk) begin
        if (rst) begin
            rdValid <= 1'b0;
        end else begin
            rdValid <= (state == SCAN_READ);
        end
        rdAddr <= scanRaddr;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= SCAN_IDLE;
            peakValid <= 1'b0;
            scanDone <= 1'b0;
        end else begin
            peakValid <= 1'b0;
            // done one cycle after the last pixel's report
            scanDone <= peakValid && (peakPixel == PIX_W'(PIXEL_NUM - 1));
            case (state)
                SCAN_IDLE: begin
                    if (scanStart) begin
                        state <= SCAN_READ;
                        pixCnt <= '0;
                        binCnt <= '0;
                        maxCount <= '0;
                        maxBin <= '0;
                    end
                end
                SCAN_READ: begin
                    binCnt <= binCnt + 1'b1;
                    if (newMax) begin
                        maxCount <= ramRdata;
                        maxBin <= rdAddr[BIN_W-1:0];
                    end
                    // last bin data arrives in the report cycle
                    if (lastBin) begin
                        state <= SCAN_REPORT;
                    end
                end
                SCAN_REPORT: begin
                    // fold in the last bin while reporting
                    peakValid <= 1'b1;
                    peakPixel <= pixCnt;
                    peakBin <= newMax ? rdAddr[BIN_W-1:0] : maxBin;
                    peakCount <= newMax ? ramRdata : maxCount;
                    maxCount <= '0;
                    maxBin <= '0;
                    binCnt <= '0;
                    if (lastPixel) begin
                        state <= SCAN_IDLE;
                    end else begin
                        pixCnt <= pixCnt + 1'b1;
                        state <= SCAN_READ;
                    end
                end
                default: begin
                    state <= SCAN_IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== histAccumulator.sv ====
`default_nettype none

module histAccumulator
    import histPkg::*;
    import ctrlPkg::*;
(
    input  wire logic               clk,
    input  wire logic               rst,
    input  wire logic               sampleValid,
    input  wire logic [PIX_W-1:0]   samplePixel,
    input  wire logic [BIN_W-1:0]   sampleBin,
    input  wire logic               frameDone,
    output logic                    acqReady,
    output logic                    scanStart,
    input  wire logic               scanDone,
    input  wire logic [ADDR_W-1:0]  scanRaddr,
    input  wire logic [ADDR_W-1:0]  scanWaddr,
    input  wire logic               scanWe,
    output logic      [ADDR_W-1:0]  ramRaddr,
    output logic      [ADDR_W-1:0]  ramWaddr,
    output logic                    ramWe,
    output logic      [COUNT_W-1:0] ramWdata,
    input  wire logic [COUNT_W-1:0] ramRdata
);

    accState_t state;
    logic drainCnt;

    // stage 0 address and acceptance
    logic accept;
    logic [ADDR_W-1:0] sampleAddr;

    // stage 1, read data arrives here
    logic s1Valid;
    logic [ADDR_W-1:0] s1Addr;

    // copy of the previous write for forwarding
    logic wbValid;
    logic [ADDR_W-1:0] wbAddr;
    logic [COUNT_W-1:0] wbData;

    logic [COUNT_W-1:0] baseCount;
    logic [COUNT_W-1:0] incCount;

    // only the run phase takes samples
    assign acqReady = (state == ACC_RUN);
    assign accept = sampleValid && acqReady;
    assign sampleAddr = {samplePixel, sampleBin};

    // ram still holds the stale word if the same address was written last cycle
    assign baseCount = (wbValid && (wbAddr == s1Addr)) ? wbData : ramRdata;
    // saturating increment
    assign incCount = (baseCount == {COUNT_W{1'b1}}) ? baseCount : baseCount + 1'b1;

    // counting pipeline
    always_ff @(posedge clk) begin
        if (rst) begin
            s1Valid <= 1'b0;
            wbValid <= 1'b0;
        end else begin
            s1Valid <= accept;
            wbValid <= s1Valid;
        end
        s1Addr <= sampleAddr;
        wbAddr <= s1Addr;
        wbData <= incCount;
    end

    // acquisition control
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ACC_RUN;
            drainCnt <= 1'b0;
            scanStart <= 1'b0;
        end else begin
            scanStart <= 1'b0;
            case (state)
                ACC_RUN: begin
                    // sample in the same cycle is already accepted
                    if (frameDone) begin
                        state <= ACC_DRAIN;
                        drainCnt <= 1'b0;
                    end
                end
                ACC_DRAIN: begin
                    // two cycles lets the last write land
                    if (drainCnt) begin
                        state <= ACC_SCAN;
                        scanStart <= 1'b1;
                    end else begin
                        drainCnt <= 1'b1;
                    end
                end
                ACC_SCAN: begin
                    if (scanDone) begin
                        state <= ACC_RUN;
                    end
                end
                default: begin
                    state <= ACC_RUN;
                end
            endcase
        end
    end

    // ram port ownership
    always_comb begin
        if (state == ACC_SCAN) begin
            // scanner reads and clears behind itself
            ramRaddr = scanRaddr;
            ramWaddr = scanWaddr;
            ramWe = scanWe;
            ramWdata = '0;
        end else begin
            ramRaddr = sampleAddr;
            ramWaddr = s1Addr;
            ramWe = s1Valid;
            ramWdata = incCount;
        end
    end

endmodule

`default_nettype wire

// ==== countRam.sv ====
`default_nettype none

module countRam
    import histPkg::*;
(
    input  wire logic               clk,
    input  wire logic               we,
    input  wire logic [ADDR_W-1:0]  waddr,
    input  wire logic [COUNT_W-1:0] wdata,
    input  wire logic [ADDR_W-1:0]  raddr,
    output logic      [COUNT_W-1:0] rdata
);

    logic [COUNT_W-1:0] mem [RAM_DEPTH];

    // histograms start empty, scans keep them empty afterwards
    initial begin
        for (int i = 0; i < RAM_DEPTH; i++) begin
            mem[i] = '0;
        end
    end

    // write port
    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // registered read, old word on a same-cycle collision
    always_ff @(posedge clk) begin
        rdata <= mem[raddr];
    end

endmodule

`default_nettype wire

// ==== ctrlPkg.sv ====
`default_nettype none

package ctrlPkg;

    // accumulator phases
    typedef enum logic [1:0] {
        ACC_RUN,
        ACC_DRAIN,
        ACC_SCAN
    } accState_t;

    // scanner phases
    typedef enum logic [1:0] {
        SCAN_IDLE,
        SCAN_READ,
        SCAN_REPORT
    } scanState_t;

endpackage

`default_nettype wire

// ==== histPkg.sv ====
`default_nettype none

package histPkg;

    // pixel array geometry
    localparam int PIXEL_NUM = 4;
    localparam int PIX_W = 2;

    // timestamp bins per pixel histogram
    localparam int BIN_NUM = 16;
    localparam int BIN_W = 4;

    // ram address is {pixel, bin}
    localparam int ADDR_W = PIX_W + BIN_W;

    // counts saturate at all ones
    localparam int COUNT_W = 8;

    // one word per pixel and bin
    localparam int RAM_DEPTH = PIXEL_NUM * BIN_NUM;

endpackage

`default_nettype wire
